//--- hdl/tx_dma_pkg.sv
package tx_dma_pkg;

  // Kind of data that a write-back from the read data mover carries.
  typedef enum logic {
    DST_PACKET     = 1'b0,
    DST_DESCRIPTOR = 1'b1
  } dst_kind_e;

  // Destination address handed to the read data mover.
  // The mover echoes it back on the write-back, so it carries job metadata.
  typedef struct packed {
    logic [32:0] pad;
    dst_kind_e   kind;
    logic [15:0] head;
    logic [7:0]  queue_id;
    logic [5:0]  align;
  } rddm_dst_addr_t;

  typedef struct packed {
    logic [63:0]    src_addr;
    rddm_dst_addr_t dst_addr;
    logic [17:0]    nb_dwords;
    logic [7:0]     dsc_id;
  } rddm_req_t;

  // One 64-byte ring entry as written by the host.
  typedef struct packed {
    logic [415:0] pad;
    logic [31:0]  length;
    logic [63:0]  addr;
  } tx_dsc_t;

  localparam logic [7:0] FETCH_DSC_ID = 8'd2;
  localparam logic [7:0] PKT_DSC_ID = 8'd1;
  localparam int unsigned DWORDS_PER_ENTRY = 16;

endpackage

//--- hdl/tx_queue_pkg.sv
package tx_queue_pkg;

  // Register targeted by a CPU write.
  typedef enum logic [1:0] {
    REG_TAIL   = 2'd0,
    REG_L_ADDR = 2'd1,
    REG_H_ADDR = 2'd2
  } reg_sel_e;

  // One descriptor fetch job.
  // The head is the tail that was current before the update.
  typedef struct packed {
    logic [7:0]  queue_id;
    logic [15:0] tail;
    logic [15:0] head;
    logic [31:0] l_addr;
    logic [31:0] h_addr;
  } q_state_t;

  // Fetch work FIFO between the tail monitor and the issuer.
  localparam int unsigned STATE_FIFO_DEPTH = 16;
  localparam int unsigned STATE_ALM_FULL = 10;

  // Request FIFOs towards the read data mover.
  localparam int unsigned REQ_FIFO_DEPTH = 16;
  localparam int unsigned REQ_ALM_FULL = 8;

endpackage

//--- hdl/queue_table_rd_if.sv
interface queue_table_rd_if #(
  parameter int QID_WIDTH = 2,
  parameter int RB_AWIDTH = 10
);

  logic                 rd_en;
  logic [QID_WIDTH-1:0] queue;
  logic [RB_AWIDTH-1:0] tail;
  logic [31:0]          l_addr;
  logic [31:0]          h_addr;

  // Read data returns two cycles after rd_en.
  modport reader (output rd_en, output queue, input tail, input l_addr, input h_addr);
  modport tbl (input rd_en, input queue, output tail, output l_addr, output h_addr);

endinterface

//--- hdl/sync_fifo.sv
module sync_fifo #(
  parameter type T = logic [7:0],
  parameter int DEPTH = 16
) (
  input  logic        clk,
  input  logic        rst,
  input  T            in_data,
  input  logic        in_valid,
  output logic        in_ready,
  output T            out_data,
  output logic        out_valid,
  input  logic        out_ready,
  output logic [31:0] occup
);

  localparam int AW = $clog2(DEPTH);
  localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          push;
  logic          pop;

  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;
  assign in_ready  = count != FULL_COUNT;
  assign out_valid = count != '0;
  assign out_data  = mem[rd_ptr];
  assign occup     = 32'(count);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap on their own since DEPTH is a power of two.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hdl/queue_state_table.sv
module queue_state_table
  import tx_queue_pkg::*;
#(
  parameter int NB_QUEUES = 4,
  parameter int RB_AWIDTH = 10,
  localparam int QID_WIDTH = $clog2(NB_QUEUES)
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cpu_wr_en,
  input  reg_sel_e             cpu_wr_sel,
  input  logic [QID_WIDTH-1:0] cpu_wr_queue,
  input  logic [31:0]          cpu_wr_data,
  queue_table_rd_if.tbl        rd
);

  logic [RB_AWIDTH-1:0] tails   [NB_QUEUES];
  logic [31:0]          l_addrs [NB_QUEUES];
  logic [31:0]          h_addrs [NB_QUEUES];

  // Tail writes are delayed so that a read issued for them still sees the old tail.
  logic                 tail_wr_r1;
  logic                 tail_wr_r2;
  logic [QID_WIDTH-1:0] tail_q_r1;
  logic [QID_WIDTH-1:0] tail_q_r2;
  logic [RB_AWIDTH-1:0] tail_d_r1;
  logic [RB_AWIDTH-1:0] tail_d_r2;

  // First read stage.
  logic [RB_AWIDTH-1:0] rd_tail_s1;
  logic [31:0]          rd_l_addr_s1;
  logic [31:0]          rd_h_addr_s1;

  always_ff @(posedge clk) begin
    if (rst) begin
      tail_wr_r1 <= 1'b0;
      tail_wr_r2 <= 1'b0;
    end else begin
      tail_wr_r1 <= cpu_wr_en && (cpu_wr_sel == REG_TAIL);
      tail_wr_r2 <= tail_wr_r1;
    end
    tail_q_r1 <= cpu_wr_queue;
    tail_q_r2 <= tail_q_r1;
    tail_d_r1 <= cpu_wr_data[RB_AWIDTH-1:0];
    tail_d_r2 <= tail_d_r1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NB_QUEUES; i++) begin
        tails[i]   <= '0;
        l_addrs[i] <= '0;
        h_addrs[i] <= '0;
      end
    end else begin
      if (tail_wr_r2) begin
        tails[tail_q_r2] <= tail_d_r2;
      end
      if (cpu_wr_en && (cpu_wr_sel == REG_L_ADDR)) begin
        l_addrs[cpu_wr_queue] <= cpu_wr_data;
      end
      if (cpu_wr_en && (cpu_wr_sel == REG_H_ADDR)) begin
        h_addrs[cpu_wr_queue] <= cpu_wr_data;
      end
    end
  end

  // Two register stages, like a BRAM with its output register.
  always_ff @(posedge clk) begin
    if (rd.rd_en) begin
      rd_tail_s1   <= tails[rd.queue];
      rd_l_addr_s1 <= l_addrs[rd.queue];
      rd_h_addr_s1 <= h_addrs[rd.queue];
    end
    rd.tail   <= rd_tail_s1;
    rd.l_addr <= rd_l_addr_s1;
    rd.h_addr <= rd_h_addr_s1;
  end

endmodule

//--- hdl/tail_monitor.sv
module tail_monitor
  import tx_queue_pkg::*;
#(
  parameter int NB_QUEUES = 4,
  parameter int RB_AWIDTH = 10,
  localparam int QID_WIDTH = $clog2(NB_QUEUES)
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cpu_wr_en,
  input  reg_sel_e             cpu_wr_sel,
  input  logic [QID_WIDTH-1:0] cpu_wr_queue,
  input  logic [31:0]          cpu_wr_data,
  input  logic [31:0]          state_occup,
  queue_table_rd_if.reader     rd,
  output q_state_t             state_data,
  output logic                 state_valid,
  output logic [31:0]          ignored_dsc_cnt
);

  logic                 tail_wr;
  logic                 alm_full;
  logic                 push;
  logic [RB_AWIDTH-1:0] old_tail;

  // New tail and queue travel alongside the table read.
  logic [RB_AWIDTH-1:0] new_tail;
  logic [RB_AWIDTH-1:0] new_tail_r1;
  logic [RB_AWIDTH-1:0] new_tail_r2;
  logic [QID_WIDTH-1:0] queue_r1;
  logic [QID_WIDTH-1:0] queue_r2;
  logic                 rd_en_r1;
  logic                 rd_en_r2;

  // Jobs enqueued in the last two cycles, not yet visible in the table.
  logic                 byp_valid [2];
  logic [QID_WIDTH-1:0] byp_queue [2];
  logic [RB_AWIDTH-1:0] byp_tail  [2];

  assign tail_wr  = cpu_wr_en && (cpu_wr_sel == REG_TAIL);
  assign alm_full = state_occup > STATE_ALM_FULL;

  always_comb begin
    if (byp_valid[0] && (byp_queue[0] == queue_r2)) begin
      old_tail = byp_tail[0];
    end else if (byp_valid[1] && (byp_queue[1] == queue_r2)) begin
      old_tail = byp_tail[1];
    end else begin
      old_tail = rd.tail;
    end
  end

  assign push = rd_en_r2 && (new_tail_r2 != old_tail);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd.rd_en        <= 1'b0;
      rd_en_r1        <= 1'b0;
      rd_en_r2        <= 1'b0;
      state_valid     <= 1'b0;
      byp_valid[0]    <= 1'b0;
      byp_valid[1]    <= 1'b0;
      ignored_dsc_cnt <= '0;
    end else begin
      rd.rd_en     <= tail_wr && !alm_full;
      rd_en_r1     <= rd.rd_en;
      rd_en_r2     <= rd_en_r1;
      state_valid  <= push;
      byp_valid[0] <= push;
      byp_valid[1] <= byp_valid[0];
      // Dropped tail writes never get their descriptors fetched.
      if (tail_wr && alm_full) begin
        ignored_dsc_cnt <= ignored_dsc_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tail_wr) begin
      rd.queue <= cpu_wr_queue;
      new_tail <= cpu_wr_data[RB_AWIDTH-1:0];
    end
    new_tail_r1 <= new_tail;
    new_tail_r2 <= new_tail_r1;
    queue_r1    <= rd.queue;
    queue_r2    <= queue_r1;

    byp_queue[0] <= queue_r2;
    byp_tail[0]  <= new_tail_r2;
    byp_queue[1] <= byp_queue[0];
    byp_tail[1]  <= byp_tail[0];

    state_data.queue_id <= 8'(queue_r2);
    state_data.tail     <= 16'(new_tail_r2);
    state_data.head     <= 16'(old_tail);
    state_data.l_addr   <= rd.l_addr;
    state_data.h_addr   <= rd.h_addr;
  end

endmodule

//--- hdl/dsc_fetch_issuer.sv
module dsc_fetch_issuer
  import tx_dma_pkg::*;
  import tx_queue_pkg::*;
#(
  parameter int RB_AWIDTH = 10
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [RB_AWIDTH:0] rb_size,
  input  q_state_t           state_data,
  input  logic               state_valid,
  output logic               state_ready,
  input  logic [31:0]        req_occup,
  output rddm_req_t          req_data,
  output logic               req_valid
);

  typedef enum logic {
    ISSUE_NORMAL,
    ISSUE_WRAP
  } issue_state_e;

  issue_state_e state;
  q_state_t     job;
  logic         pop;
  logic         wraps;
  logic [63:0]  head_src;
  logic [63:0]  job_base;
  logic [17:0]  plain_dwords;
  logic [17:0]  wrap_dwords;
  logic [17:0]  tail_dwords;

  function automatic rddm_req_t make_req(input logic [63:0] src, input logic [7:0] queue_id,
                                         input logic [15:0] head, input logic [17:0] dwords);
    rddm_req_t req;
    req                   = '0;
    req.src_addr          = src;
    req.dst_addr.kind     = DST_DESCRIPTOR;
    req.dst_addr.head     = head;
    req.dst_addr.queue_id = queue_id;
    req.nb_dwords         = dwords;
    req.dsc_id            = FETCH_DSC_ID;
    return req;
  endfunction

  // Stall while the request FIFO is almost full or a wrap half is pending.
  assign state_ready = (state == ISSUE_NORMAL) && (req_occup <= REQ_ALM_FULL);
  assign pop         = state_valid && state_ready;

  assign wraps    = state_data.tail <= state_data.head;
  assign head_src = {state_data.h_addr, state_data.l_addr} + (64'(state_data.head) << 6);
  assign job_base = {job.h_addr, job.l_addr};

  assign plain_dwords = 18'((32'(state_data.tail) - 32'(state_data.head)) * DWORDS_PER_ENTRY);
  assign wrap_dwords  = 18'((32'(rb_size) - 32'(state_data.head)) * DWORDS_PER_ENTRY);
  assign tail_dwords  = 18'(32'(job.tail) * DWORDS_PER_ENTRY);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ISSUE_NORMAL;
      req_valid <= 1'b0;
    end else begin
      req_valid <= 1'b0;
      case (state)
        ISSUE_NORMAL: begin
          if (pop) begin
            req_valid <= 1'b1;
            // A wrap to tail zero needs no second half.
            if (wraps && (state_data.tail != '0)) begin
              state <= ISSUE_WRAP;
            end
          end
        end
        ISSUE_WRAP: begin
          req_valid <= 1'b1;
          state     <= ISSUE_NORMAL;
        end
        default: state <= ISSUE_NORMAL;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ISSUE_WRAP) begin
      req_data <= make_req(job_base, job.queue_id, 16'd0, tail_dwords);
    end else if (pop) begin
      job <= state_data;
      if (wraps) begin
        req_data <= make_req(head_src, state_data.queue_id, state_data.head, wrap_dwords);
      end else begin
        req_data <= make_req(head_src, state_data.queue_id, state_data.head, plain_dwords);
      end
    end
  end

endmodule

//--- hdl/dsc_decoder.sv
module dsc_decoder
  import tx_dma_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         rddm_write,
  input  logic [63:0]  rddm_address,
  input  logic [511:0] rddm_writedata,
  output rddm_req_t    req_data,
  output logic         req_valid
);

  rddm_dst_addr_t wb_dst;
  rddm_dst_addr_t pkt_dst;
  tx_dsc_t        wb_dsc;
  logic           is_dsc;

  assign wb_dst = rddm_address;
  assign wb_dsc = rddm_writedata;

  // Packet write-backs are not handled here.
  assign is_dsc = rddm_write && (wb_dst.kind == DST_DESCRIPTOR);

  // Queue and head stay as found in the write address.
  always_comb begin
    pkt_dst      = wb_dst;
    pkt_dst.kind = DST_PACKET;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= is_dsc;
    end
  end

  always_ff @(posedge clk) begin
    if (is_dsc) begin
      req_data.src_addr  <= wb_dsc.addr;
      req_data.dst_addr  <= pkt_dst;
      // Bytes rounded up to whole dwords.
      req_data.nb_dwords <= 18'((33'(wb_dsc.length) + 33'd3) >> 2);
      req_data.dsc_id    <= PKT_DSC_ID;
    end
  end

endmodule

//--- hdl/tx_fetch_engine.sv
module tx_fetch_engine
  import tx_dma_pkg::*;
  import tx_queue_pkg::*;
#(
  parameter int NB_QUEUES = 4,
  parameter int RB_AWIDTH = 10,
  localparam int QID_WIDTH = $clog2(NB_QUEUES)
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [RB_AWIDTH:0]   rb_size,
  input  logic                 cpu_wr_en,
  input  reg_sel_e             cpu_wr_sel,
  input  logic [QID_WIDTH-1:0] cpu_wr_queue,
  input  logic [31:0]          cpu_wr_data,
  output rddm_req_t            fetch_req_data,
  output logic                 fetch_req_valid,
  input  logic                 fetch_req_ready,
  output rddm_req_t            pkt_req_data,
  output logic                 pkt_req_valid,
  input  logic                 pkt_req_ready,
  input  logic                 rddm_write,
  input  logic [63:0]          rddm_address,
  input  logic [511:0]         rddm_writedata,
  output logic [31:0]          ignored_dsc_cnt
);

  q_state_t    state_in_data;
  logic        state_in_valid;
  q_state_t    state_out_data;
  logic        state_out_valid;
  logic        state_out_ready;
  logic [31:0] state_occup;

  rddm_req_t   fetch_in_data;
  logic        fetch_in_valid;
  logic [31:0] fetch_occup;

  rddm_req_t   pkt_in_data;
  logic        pkt_in_valid;

  queue_table_rd_if #(.QID_WIDTH(QID_WIDTH), .RB_AWIDTH(RB_AWIDTH)) table_rd ();

  ////////////////////////////////////////////////////////////
  // Queue state and tail monitoring
  ////////////////////////////////////////////////////////////

  queue_state_table #(.NB_QUEUES(NB_QUEUES), .RB_AWIDTH(RB_AWIDTH)) u_table (
    .clk          (clk),
    .rst          (rst),
    .cpu_wr_en    (cpu_wr_en),
    .cpu_wr_sel   (cpu_wr_sel),
    .cpu_wr_queue (cpu_wr_queue),
    .cpu_wr_data  (cpu_wr_data),
    .rd           (table_rd)
  );

  tail_monitor #(.NB_QUEUES(NB_QUEUES), .RB_AWIDTH(RB_AWIDTH)) u_monitor (
    .clk             (clk),
    .rst             (rst),
    .cpu_wr_en       (cpu_wr_en),
    .cpu_wr_sel      (cpu_wr_sel),
    .cpu_wr_queue    (cpu_wr_queue),
    .cpu_wr_data     (cpu_wr_data),
    .state_occup     (state_occup),
    .rd              (table_rd),
    .state_data      (state_in_data),
    .state_valid     (state_in_valid),
    .ignored_dsc_cnt (ignored_dsc_cnt)
  );

  sync_fifo #(.T(q_state_t), .DEPTH(STATE_FIFO_DEPTH)) state_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (state_in_data),
    .in_valid  (state_in_valid),
    .in_ready  (),
    .out_data  (state_out_data),
    .out_valid (state_out_valid),
    .out_ready (state_out_ready),
    .occup     (state_occup)
  );

  ////////////////////////////////////////////////////////////
  // Descriptor fetch requests
  ////////////////////////////////////////////////////////////

  dsc_fetch_issuer #(.RB_AWIDTH(RB_AWIDTH)) u_issuer (
    .clk         (clk),
    .rst         (rst),
    .rb_size     (rb_size),
    .state_data  (state_out_data),
    .state_valid (state_out_valid),
    .state_ready (state_out_ready),
    .req_occup   (fetch_occup),
    .req_data    (fetch_in_data),
    .req_valid   (fetch_in_valid)
  );

  sync_fifo #(.T(rddm_req_t), .DEPTH(REQ_FIFO_DEPTH)) fetch_req_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (fetch_in_data),
    .in_valid  (fetch_in_valid),
    .in_ready  (),
    .out_data  (fetch_req_data),
    .out_valid (fetch_req_valid),
    .out_ready (fetch_req_ready),
    .occup     (fetch_occup)
  );

  ////////////////////////////////////////////////////////////
  // Packet read requests from written-back descriptors
  ////////////////////////////////////////////////////////////

  dsc_decoder u_decoder (
    .clk            (clk),
    .rst            (rst),
    .rddm_write     (rddm_write),
    .rddm_address   (rddm_address),
    .rddm_writedata (rddm_writedata),
    .req_data       (pkt_in_data),
    .req_valid      (pkt_in_valid)
  );

  sync_fifo #(.T(rddm_req_t), .DEPTH(REQ_FIFO_DEPTH)) pkt_req_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (pkt_in_data),
    .in_valid  (pkt_in_valid),
    .in_ready  (),
    .out_data  (pkt_req_data),
    .out_valid (pkt_req_valid),
    .out_ready (pkt_req_ready),
    .occup     ()
  );

endmodule

//--- testbench/tx_fetch_assertions.sv
module tx_fetch_assertions
  import tx_dma_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input rddm_req_t   fetch_req_data,
  input logic        fetch_req_valid,
  input logic        fetch_req_ready,
  input rddm_req_t   pkt_req_data,
  input logic        pkt_req_valid,
  input logic        pkt_req_ready,
  input logic [31:0] ignored_dsc_cnt
);

  // A stalled request holds its contents until it is taken.
  fetch_held: assert property (@(posedge clk) disable iff (rst)
    fetch_req_valid && !fetch_req_ready |=> $stable(fetch_req_data))
    else $error("fetch request changed while stalled");

  pkt_held: assert property (@(posedge clk) disable iff (rst)
    pkt_req_valid && !pkt_req_ready |=> $stable(pkt_req_data))
    else $error("packet request changed while stalled");

  // Every packet read moves at least one dword.
  pkt_not_empty: assert property (@(posedge clk) disable iff (rst)
    pkt_req_valid |-> pkt_req_data.nb_dwords != '0)
    else $error("packet request with zero dwords");

  cnt_cleared: assert property (@(posedge clk) rst |=> ignored_dsc_cnt == '0)
    else $error("drop counter not cleared by reset");

endmodule

bind tx_fetch_engine tx_fetch_assertions u_assertions (
  .clk             (clk),
  .rst             (rst),
  .fetch_req_data  (fetch_req_data),
  .fetch_req_valid (fetch_req_valid),
  .fetch_req_ready (fetch_req_ready),
  .pkt_req_data    (pkt_req_data),
  .pkt_req_valid   (pkt_req_valid),
  .pkt_req_ready   (pkt_req_ready),
  .ignored_dsc_cnt (ignored_dsc_cnt)
);

//--- testbench/tx_fetch_tb.sv
module tx_fetch_tb
  import tx_dma_pkg::*;
  import tx_queue_pkg::*;
();

  localparam int NB_QUEUES = 4;
  localparam int RB_AWIDTH = 10;
  localparam int RB_SIZE = 16;
  localparam int ENTRY_DWORDS = 16;
  localparam int TIMEOUT = 100;
  localparam int QUIET_WINDOW = 40;
  localparam int DRAIN_IDLE = 50;

  logic               clk;
  logic               rst;
  logic [RB_AWIDTH:0] rb_size;
  logic               cpu_wr_en;
  reg_sel_e           cpu_wr_sel;
  logic [1:0]         cpu_wr_queue;
  logic [31:0]        cpu_wr_data;
  rddm_req_t          fetch_req_data;
  logic               fetch_req_valid;
  logic               fetch_req_ready;
  rddm_req_t          pkt_req_data;
  logic               pkt_req_valid;
  logic               pkt_req_ready;
  logic               rddm_write;
  logic [63:0]        rddm_address;
  logic [511:0]       rddm_writedata;
  logic [31:0]        ignored_dsc_cnt;

  integer      seed;
  logic [63:0] base [NB_QUEUES];

  tx_fetch_engine #(.NB_QUEUES(NB_QUEUES), .RB_AWIDTH(RB_AWIDTH)) dut (
    .clk             (clk),
    .rst             (rst),
    .rb_size         (rb_size),
    .cpu_wr_en       (cpu_wr_en),
    .cpu_wr_sel      (cpu_wr_sel),
    .cpu_wr_queue    (cpu_wr_queue),
    .cpu_wr_data     (cpu_wr_data),
    .fetch_req_data  (fetch_req_data),
    .fetch_req_valid (fetch_req_valid),
    .fetch_req_ready (fetch_req_ready),
    .pkt_req_data    (pkt_req_data),
    .pkt_req_valid   (pkt_req_valid),
    .pkt_req_ready   (pkt_req_ready),
    .rddm_write      (rddm_write),
    .rddm_address    (rddm_address),
    .rddm_writedata  (rddm_writedata),
    .ignored_dsc_cnt (ignored_dsc_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string msg);
    if (actual !== expected) begin
      abort_run($sformatf("mismatch at time %0t: %s (got %h, expected %h)",
                          $time, msg, actual, expected));
    end
  endtask

  // Inputs change just after the rising edge.
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Destination word as the read data mover sees it.
  function automatic logic [63:0] dst_word(input logic kind, input int q, input int head);
    return {33'd0, kind, head[15:0], q[7:0], 6'd0};
  endfunction

  task automatic write_reg(input int q, input reg_sel_e sel, input logic [31:0] data);
    cpu_wr_en    = 1'b1;
    cpu_wr_sel   = sel;
    cpu_wr_queue = q[1:0];
    cpu_wr_data  = data;
    next_cycle();
    cpu_wr_en = 1'b0;
  endtask

  // Ring bases are 64-byte aligned.
  task automatic set_base(input int q);
    logic [31:0] lo;
    logic [31:0] hi;
    lo = $random(seed) & 32'hffff_ffc0;
    hi = $random(seed);
    base[q] = {hi, lo};
    write_reg(q, REG_L_ADDR, lo);
    write_reg(q, REG_H_ADDR, hi);
  endtask

  task automatic send_writeback(input logic [63:0] addr, input logic [511:0] data);
    rddm_write     = 1'b1;
    rddm_address   = addr;
    rddm_writedata = data;
    next_cycle();
    rddm_write = 1'b0;
  endtask

  task automatic compare_req(input rddm_req_t actual, input logic [63:0] src,
                             input logic [63:0] dst, input int dwords, input int id,
                             input string what);
    check(actual.src_addr, src, {what, " source address"});
    check(64'(actual.dst_addr), dst, {what, " destination address"});
    check(64'(actual.nb_dwords), 64'(dwords), {what, " dword count"});
    check(64'(actual.dsc_id), 64'(id), {what, " descriptor id"});
  endtask

  task automatic expect_fetch_req(input int q, input int head, input int dwords);
    int waited;
    waited = 0;
    while (!fetch_req_valid && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (!fetch_req_valid) begin
      abort_run("timeout while waiting for a descriptor fetch request");
    end else begin
      compare_req(fetch_req_data, base[q] + 64'(head) * 64'd64, dst_word(1'b1, q, head),
                  dwords, 2, "fetch request");
      fetch_req_ready = 1'b1;
      next_cycle();
      fetch_req_ready = 1'b0;
    end
  endtask

  task automatic expect_pkt_req(input logic [63:0] src, input logic [63:0] dst,
                                input int dwords);
    int waited;
    waited = 0;
    while (!pkt_req_valid && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (!pkt_req_valid) begin
      abort_run("timeout while waiting for a packet read request");
    end else begin
      compare_req(pkt_req_data, src, dst, dwords, 1, "packet request");
      pkt_req_ready = 1'b1;
      next_cycle();
      pkt_req_ready = 1'b0;
    end
  endtask

  // A range that reaches the ring end is split at the wrap.
  task automatic expect_fetch_range(input int q, input int head, input int tail);
    if (tail > head) begin
      expect_fetch_req(q, head, (tail - head) * ENTRY_DWORDS);
    end else begin
      expect_fetch_req(q, head, (RB_SIZE - head) * ENTRY_DWORDS);
      if (tail != 0) begin
        expect_fetch_req(q, 0, tail * ENTRY_DWORDS);
      end
    end
  endtask

  task automatic expect_quiet(input int window);
    int   waited;
    logic seen;
    seen = 1'b0;
    for (waited = 0; waited < window; waited++) begin
      seen = seen | fetch_req_valid | pkt_req_valid;
      next_cycle();
    end
    if (seen) begin
      abort_run("unexpected request while the DUT should stay idle");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_plain_fetch();
    set_base(1);
    write_reg(1, REG_TAIL, 32'd5);
    expect_fetch_range(1, 0, 5);
  endtask

  // Second write arrives before the table holds the first tail.
  task automatic test_back_to_back();
    set_base(2);
    write_reg(2, REG_TAIL, 32'd3);
    write_reg(2, REG_TAIL, 32'd7);
    expect_fetch_range(2, 0, 3);
    expect_fetch_range(2, 3, 7);
  endtask

  task automatic test_wrap();
    set_base(3);
    write_reg(3, REG_TAIL, 32'd12);
    expect_fetch_range(3, 0, 12);
    write_reg(3, REG_TAIL, 32'd4);
    expect_fetch_range(3, 12, 4);
    write_reg(3, REG_TAIL, 32'd0);
    expect_fetch_range(3, 4, 0);
    expect_quiet(QUIET_WINDOW);
  endtask

  task automatic test_same_tail();
    write_reg(1, REG_TAIL, 32'd5);
    expect_quiet(QUIET_WINDOW);
    // No tail write has been dropped so far.
    check(64'(ignored_dsc_cnt), 64'd0, "drop counter after unchanged tail");
    // Queue 1 still continues from tail 5.
    write_reg(1, REG_TAIL, 32'd9);
    expect_fetch_range(1, 5, 9);
  endtask

  task automatic test_writeback();
    logic [63:0] buf_addr;
    logic [31:0] len;
    logic [15:0] head;
    int          dwords;
    for (int q = 0; q < NB_QUEUES; q++) begin
      buf_addr = {$random(seed), $random(seed)};
      len      = ($random(seed) & 32'h0000_3fff) + 32'd1;
      head     = 16'($random(seed)) & 16'h000f;
      dwords   = int'(len / 4) + ((len % 4 != 0) ? 1 : 0);
      send_writeback(dst_word(1'b1, q, int'(head)), {416'd0, len, buf_addr});
      expect_pkt_req(buf_addr, dst_word(1'b0, q, int'(head)), dwords);
    end
    send_writeback(dst_word(1'b0, 2, 7), {416'd0, 32'd100, 64'h1000});
    expect_quiet(QUIET_WINDOW);
  endtask

  task automatic test_backpressure();
    int drained;
    int idle;
    set_base(0);
    // Ready stays low, so the request and state FIFOs fill up.
    for (int t = 1; t <= 30; t++) begin
      write_reg(0, REG_TAIL, 32'(t));
    end
    drained = 0;
    idle    = 0;
    fetch_req_ready = 1'b1;
    while (idle < DRAIN_IDLE && drained < 64) begin
      if (fetch_req_valid) begin
        // Drops only start once the FIFOs are full, so request n covers entry n.
        compare_req(fetch_req_data, base[0] + 64'(drained) * 64'd64,
                    dst_word(1'b1, 0, drained), ENTRY_DWORDS, 2, "drained request");
        drained++;
        idle = 0;
      end else begin
        idle++;
      end
      next_cycle();
    end
    fetch_req_ready = 1'b0;
    if (drained == 0) begin
      abort_run("no fetch request came out after back-pressure was released");
    end else begin
      check(64'(ignored_dsc_cnt), 64'(30 - drained), "dropped tail writes");
    end
  endtask

  initial begin
    seed            = 32'h6b52;
    rst             = 1'b1;
    rb_size         = (RB_AWIDTH + 1)'(RB_SIZE);
    cpu_wr_en       = 1'b0;
    cpu_wr_sel      = REG_TAIL;
    cpu_wr_queue    = '0;
    cpu_wr_data     = '0;
    fetch_req_ready = 1'b0;
    pkt_req_ready   = 1'b0;
    rddm_write      = 1'b0;
    rddm_address    = '0;
    rddm_writedata  = '0;
    repeat (10) next_cycle();
    rst = 1'b0;
    next_cycle();

    test_plain_fetch();
    test_back_to_back();
    test_wrap();
    test_same_tail();
    test_writeback();
    test_backpressure();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- list.f
hdl/tx_dma_pkg.sv
hdl/tx_queue_pkg.sv
hdl/queue_table_rd_if.sv
hdl/sync_fifo.sv
hdl/queue_state_table.sv
hdl/tail_monitor.sv
hdl/dsc_fetch_issuer.sv
hdl/dsc_decoder.sv
hdl/tx_fetch_engine.sv
testbench/tx_fetch_assertions.sv
testbench/tx_fetch_tb.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tx_fetch_tb \
  -f list.f -o tx_fetch_sim && ./obj_dir/tx_fetch_sim > sim.log 2>&1
cat sim.log
grep -q '^TESTS PASSED$' sim.log || exit 1
